/* include/alu_consts.svh */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Datapath and register file size
`define ALU_WIDTH 16
`define ALU_NREGS 8

// APB byte address map
`define ALU_ADDR_REG_END 8'h1C
`define ALU_ADDR_CMD 8'h20
`define ALU_ADDR_STATUS 8'h24

// Position field taken from operand B
`define ALU_POS_BITS 4

`endif

/* rtl/alu_pkg.sv */
`include "alu_consts.svh"

package alu_pkg;

	typedef enum logic [3:0] {
		OP_MOV, OP_ADD, OP_SUB, OP_MUL,
		OP_OR, OP_AND, OP_XOR, OP_SL,
		OP_SR, OP_SRA, OP_ROT, OP_BIT,
		OP_SET, OP_CLR, OP_CMP, OP_SEX
	} alu_op_t;

	// Same bit order as STATUS[4:1]
	typedef struct packed {
		logic sign;
		logic carry;
		logic zero;
		logic parity; // Overflow for arithmetic ops
	} alu_flags_t;

	typedef logic [$clog2(`ALU_NREGS)-1:0] reg_addr_t;

	typedef struct packed {
		logic [2:0] reps; // Iterations minus one
		reg_addr_t rb;
		reg_addr_t ra;
		reg_addr_t rd;
		alu_op_t op;
	} cmd_t;

endpackage

/* rtl/rf_if.sv */
`include "alu_consts.svh"

interface rf_if;
	import alu_pkg::*;

	reg_addr_t a_addr; // Operand A select
	reg_addr_t b_addr; // Operand B select
	logic [`ALU_WIDTH-1:0] a_data;
	logic [`ALU_WIDTH-1:0] b_data;
	logic wr_en;
	reg_addr_t wr_addr;
	logic [`ALU_WIDTH-1:0] wr_data;

	modport seq (
		output a_addr, b_addr, wr_en, wr_addr, wr_data,
		input a_data, b_data
	);

	modport store (
		input a_addr, b_addr, wr_en, wr_addr, wr_data,
		output a_data, b_data
	);

endinterface

/* rtl/alu.sv */
`include "alu_consts.svh"

module alu (
	input alu_pkg::alu_op_t op,
	input logic signed [`ALU_WIDTH-1:0] arg_a,
	input logic signed [`ALU_WIDTH-1:0] arg_b,
	output logic [`ALU_WIDTH-1:0] result,
	output alu_pkg::alu_flags_t flags
);
	import alu_pkg::*;

	logic [`ALU_POS_BITS-1:0] pos;
	logic [`ALU_WIDTH-1:0] onehot;
	logic [`ALU_WIDTH-1:0] mask;
	logic signed [2*`ALU_WIDTH-1:0] prod;
	logic [2*`ALU_WIDTH-1:0] rot;
	logic carry;
	logic ovfl;
	logic arith;

	assign pos = arg_b[`ALU_POS_BITS-1:0]; // Only low bits act as position
	assign onehot = {{(`ALU_WIDTH-1){1'b0}}, 1'b1} << pos;
	assign mask = {`ALU_WIDTH{1'b1}} << pos; // Bits from pos upward
	assign prod = arg_a * arg_b;
	assign rot = {arg_a, arg_a} >> pos;

	always_comb begin
		carry = 1'b0;
		ovfl = 1'b0;
		arith = 1'b0;
		case (op)
			OP_MOV: begin
				result = arg_b;
			end
			OP_ADD: begin
				{carry, result} = {1'b0, arg_a} + {1'b0, arg_b}; // Unsigned carry out
				arith = 1'b1;
			end
			OP_SUB: begin
				{carry, result} = {1'b0, arg_a} - {1'b0, arg_b}; // Borrow
				arith = 1'b1;
			end
			OP_MUL: begin
				result = prod[`ALU_WIDTH-1:0];
				ovfl = |prod[2*`ALU_WIDTH-1:`ALU_WIDTH];
				arith = 1'b1;
			end
			OP_OR: begin
				result = arg_a | arg_b;
			end
			OP_AND: begin
				result = arg_a & arg_b;
			end
			OP_XOR: begin
				result = arg_a ^ arg_b;
			end
			OP_SL: begin
				{carry, result} = {1'b0, arg_a} << pos; // Last bit shifted out
			end
			OP_SR: begin
				result = $unsigned(arg_a) >> pos;
			end
			OP_SRA: begin
				result = arg_a >>> pos; // Sign bit fills in
			end
			OP_ROT: begin
				result = rot[`ALU_WIDTH-1:0];
			end
			OP_BIT: begin
				result = arg_a & onehot;
			end
			OP_SET: begin
				result = arg_a | onehot;
			end
			OP_CLR: begin
				result = arg_a & ~onehot;
			end
			OP_CMP: begin
				result = arg_a - arg_b; // Flags only
				arith = 1'b1;
			end
			OP_SEX: begin
				if (arg_a[pos]) begin
					result = arg_a | mask;
				end else begin
					result = arg_a & ~mask;
				end
				arith = 1'b1;
			end
			default: begin
				result = arg_b;
			end
		endcase

		flags.sign = result[`ALU_WIDTH-1];
		flags.carry = carry;
		flags.zero = (result == '0);
		flags.parity = arith ? ovfl : result[0];
	end

endmodule

/* rtl/rep_counter.sv */
module rep_counter (
	input logic clk,
	input logic reset,
	input logic load,
	input logic [2:0] count,
	input logic step,
	output logic last
);

	logic [2:0] count_q;
	logic armed; // A loaded run is in progress

	always_ff @(posedge clk) begin
		if (reset) begin
			count_q <= '0;
			armed <= 1'b0;
		end else if (load) begin
			count_q <= count;
			armed <= 1'b1;
		end else if (step) begin
			if (count_q != '0) begin
				count_q <= count_q - 3'd1;
			end
			armed <= (count_q != '0); // Disarm after final step
		end
	end

	assign last = (count_q == '0);

	step_needs_load: assert property (@(posedge clk) disable iff (reset)
		step |-> armed);

endmodule

/* rtl/reg_file.sv */
`include "alu_consts.svh"

module reg_file (
	input logic clk,
	input logic reset,
	rf_if.store rf,
	input alu_pkg::reg_addr_t host_addr,
	input logic [`ALU_WIDTH-1:0] host_wdata,
	input logic host_we,
	output logic [`ALU_WIDTH-1:0] host_rdata
);

	logic [`ALU_WIDTH-1:0] regs [`ALU_NREGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `ALU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (rf.wr_en) begin
				regs[rf.wr_addr] <= rf.wr_data; // Sequencer result
			end
			if (host_we) begin
				regs[host_addr] <= host_wdata;
			end
		end
	end

	// Combinational read ports
	assign rf.a_data = regs[rf.a_addr];
	assign rf.b_data = regs[rf.b_addr];
	assign host_rdata = regs[host_addr];

	// Host writes are refused while a command runs, so both ports never collide
	no_dual_write: assert property (@(posedge clk) disable iff (reset)
		!(rf.wr_en && host_we));

endmodule

/* rtl/exec_ctrl.sv */
`include "alu_consts.svh"

module exec_ctrl (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input alu_pkg::cmd_t cmd,
	output logic busy,
	output alu_pkg::alu_flags_t flags,
	rf_if.seq rf
);
	import alu_pkg::*;

	typedef enum logic {IDLE, EXEC} state_t;

	state_t state;
	cmd_t cmd_q;
	logic first; // First iteration reads Ra
	logic last;
	logic [`ALU_WIDTH-1:0] alu_result;
	alu_flags_t alu_flags;

	alu u_alu (
		.op(cmd_q.op),
		.arg_a(rf.a_data),
		.arg_b(rf.b_data),
		.result(alu_result),
		.flags(alu_flags)
	);

	rep_counter u_reps (
		.clk(clk),
		.reset(reset),
		.load(cmd_valid),
		.count(cmd.reps),
		.step(busy), // One step per EXEC cycle
		.last(last)
	);

	assign busy = (state == EXEC);

	// Later iterations feed Rd back as operand A
	assign rf.a_addr = first ? cmd_q.ra : cmd_q.rd;
	assign rf.b_addr = cmd_q.rb;
	assign rf.wr_en = busy && (cmd_q.op != OP_CMP);
	assign rf.wr_addr = cmd_q.rd;
	assign rf.wr_data = alu_result;

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			cmd_q <= cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			first <= 1'b0;
			flags <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (cmd_valid) begin
						state <= EXEC;
						first <= 1'b1;
					end
				end
				EXEC: begin
					flags <= alu_flags; // Flags of every iteration
					first <= 1'b0;
					if (last) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	no_cmd_while_busy: assert property (@(posedge clk) disable iff (reset)
		cmd_valid |-> !busy);

endmodule

/* rtl/apb_regs.sv */
`include "alu_consts.svh"

module apb_regs (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output alu_pkg::reg_addr_t host_addr,
	output logic [`ALU_WIDTH-1:0] host_wdata,
	output logic host_we,
	input logic [`ALU_WIDTH-1:0] host_rdata,
	output logic cmd_valid,
	output alu_pkg::cmd_t cmd,
	input logic busy,
	input alu_pkg::alu_flags_t flags
);
	import alu_pkg::*;

	logic setup;
	logic access;
	logic is_reg;
	logic is_cmd;
	logic is_status;
	logic err;
	logic pslverr_q;
	logic [31:0] prdata_q;
	logic [31:0] rd_mux;
	cmd_t last_cmd; // Readback of CMD

	assign setup = psel && !penable;
	assign access = psel && penable;

	// Word aligned decode
	assign is_reg = (paddr <= `ALU_ADDR_REG_END) && (paddr[1:0] == 2'b00);
	assign is_cmd = (paddr == `ALU_ADDR_CMD);
	assign is_status = (paddr == `ALU_ADDR_STATUS);

	assign err = !(is_reg || is_cmd || is_status)
		|| (pwrite && is_status)
		|| (pwrite && (is_reg || is_cmd) && busy);

	always_comb begin
		rd_mux = '0;
		if (is_reg) begin
			rd_mux[`ALU_WIDTH-1:0] = host_rdata;
		end else if (is_cmd) begin
			rd_mux[`ALU_WIDTH-1:0] = last_cmd;
		end else if (is_status) begin
			rd_mux[4:0] = {flags, busy}; // Busy in bit 0
		end
	end

	// Response is prepared in the setup phase
	always_ff @(posedge clk) begin
		if (reset) begin
			pslverr_q <= 1'b0;
		end else if (setup) begin
			pslverr_q <= err;
		end
	end

	always_ff @(posedge clk) begin
		if (setup && !pwrite) begin
			prdata_q <= rd_mux;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			last_cmd <= '0;
		end else if (cmd_valid) begin
			last_cmd <= cmd;
		end
	end

	assign prdata = prdata_q;
	assign pready = 1'b1; // No wait states
	assign pslverr = access && pslverr_q;

	assign host_addr = paddr[4:2];
	assign host_wdata = pwdata[`ALU_WIDTH-1:0];
	assign host_we = access && pwrite && is_reg && !pslverr_q;

	assign cmd = cmd_t'(pwdata[`ALU_WIDTH-1:0]);
	assign cmd_valid = access && pwrite && is_cmd && !pslverr_q;

endmodule

/* rtl/alu_unit_top.sv */
`include "alu_consts.svh"

module alu_unit_top (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	import alu_pkg::*;

	reg_addr_t host_addr;
	logic [`ALU_WIDTH-1:0] host_wdata;
	logic host_we;
	logic [`ALU_WIDTH-1:0] host_rdata;
	logic cmd_valid;
	cmd_t cmd;
	logic busy;
	alu_flags_t flags;

	rf_if rf ();

	apb_regs u_apb (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_we(host_we),
		.host_rdata(host_rdata),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.busy(busy),
		.flags(flags)
	);

	exec_ctrl u_exec (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.busy(busy),
		.flags(flags),
		.rf(rf.seq)
	);

	reg_file u_regs (
		.clk(clk),
		.reset(reset),
		.rf(rf.store),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_we(host_we),
		.host_rdata(host_rdata)
	);

endmodule

/* test/tb_clock.sv */
module tb_clock (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 2;
	localparam int RELEASE_DLY = 2; // Same offset as the APB drive

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#RELEASE_DLY reset = 1'b0;
	end

endmodule

/* test/tb_alu_unit.sv */
`include "alu_consts.svh"

module tb_alu_unit;
	import alu_pkg::*;

	localparam int DRIVE_DLY = 2;
	localparam int SAMPLE_DLY = 8; // Mid cycle where outputs are settled
	localparam int READY_LIMIT = 8;
	localparam int POLL_LIMIT = 40;
	localparam int RESET_LIMIT = 10;
	localparam int VEC_WORDS = 8;
	localparam int MAX_VECS = 32;
	localparam logic [7:0] ADDR_BAD = 8'h30;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	integer seed;
	int value_errors;
	int other_errors;
	logic [15:0] vec_mem [0:VEC_WORDS*MAX_VECS-1];
	logic [`ALU_WIDTH-1:0] rand_vals [`ALU_NREGS];
	alu_flags_t last_flags; // Expected flags of the latest command

	tb_clock u_clk (
		.clk(clk),
		.reset(reset)
	);

	alu_unit_top uut (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	function automatic logic [7:0] reg_byte_addr(input int n);
		return 8'(4 * n);
	endfunction

	task automatic check_word(input logic [`ALU_WIDTH-1:0] expected,
		input logic [`ALU_WIDTH-1:0] actual, input string name);
		if (actual !== expected) begin
			$display("** Error: %s expected %h got %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_flags(input alu_flags_t expected, input alu_flags_t actual,
		input string name);
		if (actual !== expected) begin
			$display("** Error: %s expected %h got %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_bit(input logic expected, input logic actual, input string name);
		if (actual !== expected) begin
			$display("** Error: %s expected %h got %h", name, expected, actual);
			value_errors++;
		end
	endtask

	// One setup cycle, then access until pready
	task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int n;
		n = 0;
		@(posedge clk);
		#DRIVE_DLY;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#DRIVE_DLY;
		penable = 1'b1;
		#SAMPLE_DLY;
		while (pready !== 1'b1 && n < READY_LIMIT) begin
			@(posedge clk);
			#(DRIVE_DLY + SAMPLE_DLY);
			n++;
		end
		if (pready !== 1'b1) begin
			$display("APB transfer to address %h never completed", addr);
			other_errors++;
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#DRIVE_DLY;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata, output logic err);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, wdata, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata, output logic err);
		apb_xfer(1'b0, addr, 32'h0, rdata, err);
	endtask

	task automatic wait_idle;
		logic [31:0] status;
		logic err;
		int polls;
		polls = 0;
		apb_read(`ALU_ADDR_STATUS, status, err);
		while (status[0] !== 1'b0 && polls < POLL_LIMIT) begin
			apb_read(`ALU_ADDR_STATUS, status, err);
			polls++;
		end
		if (status[0] !== 1'b0) begin
			$display("Command still busy after %0d status polls", POLL_LIMIT);
			other_errors++;
		end
	endtask

	// Ra = R1, Rb = R2, Rd = R3 for every vector
	task automatic run_vector(input int base);
		logic [15:0] kind;
		logic [31:0] rdata;
		logic err;
		cmd_t cmd;
		cmd_t stray;
		kind = vec_mem[base];
		cmd.op = alu_op_t'(vec_mem[base+1][3:0]);
		cmd.rd = 3'd3;
		cmd.ra = 3'd1;
		cmd.rb = 3'd2;
		cmd.reps = vec_mem[base+4][2:0];
		apb_write(reg_byte_addr(1), {16'h0, vec_mem[base+2]}, err);
		check_bit(1'b0, err, "pslverr");
		apb_write(reg_byte_addr(2), {16'h0, vec_mem[base+3]}, err);
		check_bit(1'b0, err, "pslverr");
		apb_write(reg_byte_addr(3), {16'h0, vec_mem[base+5]}, err);
		check_bit(1'b0, err, "pslverr");
		apb_write(`ALU_ADDR_CMD, {16'h0, cmd}, err);
		check_bit(1'b0, err, "pslverr");
		if (kind == 16'h4) begin
			stray = cmd;
			stray.op = OP_ADD;
			stray.rd = 3'd6;
			apb_write(`ALU_ADDR_CMD, {16'h0, stray}, err); // Refused while busy
			check_bit(1'b1, err, "pslverr on busy CMD write");
			apb_write(reg_byte_addr(5), 32'h0000dead, err);
			check_bit(1'b1, err, "pslverr on busy R5 write");
		end
		wait_idle();
		apb_read(reg_byte_addr(3), rdata, err);
		check_word(vec_mem[base+6], rdata[`ALU_WIDTH-1:0], "R3");
		last_flags = alu_flags_t'(vec_mem[base+7][3:0]);
		apb_read(`ALU_ADDR_STATUS, rdata, err);
		check_flags(last_flags, alu_flags_t'(rdata[4:1]), "flags");
		if (kind == 16'h4) begin
			apb_read(reg_byte_addr(5), rdata, err);
			check_word(rand_vals[5], rdata[`ALU_WIDTH-1:0], "R5");
			apb_read(reg_byte_addr(6), rdata, err);
			check_word(rand_vals[6], rdata[`ALU_WIDTH-1:0], "R6");
			apb_read(`ALU_ADDR_CMD, rdata, err);
			check_word(cmd, rdata[`ALU_WIDTH-1:0], "CMD");
		end
	endtask

	initial begin
		logic [31:0] rdata;
		logic [31:0] rnd;
		logic err;
		int n;
		int v;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		seed = 83698;
		value_errors = 0;
		other_errors = 0;
		last_flags = '0;
		for (int i = 0; i < VEC_WORDS * MAX_VECS; i++) begin
			vec_mem[i] = '0; // Zero kind ends the list
		end
		$readmemh("test/alu_input.txt", vec_mem);

		n = 0;
		while (reset !== 1'b0 && n < RESET_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (reset !== 1'b0) begin
			$display("Reset was never released");
			other_errors++;
		end

		// State after reset
		apb_read(`ALU_ADDR_STATUS, rdata, err);
		check_word(16'h0000, rdata[`ALU_WIDTH-1:0], "STATUS");
		check_bit(1'b0, err, "pslverr");
		for (int i = 0; i < `ALU_NREGS; i++) begin
			apb_read(reg_byte_addr(i), rdata, err);
			check_word(16'h0000, rdata[`ALU_WIDTH-1:0], $sformatf("R%0d", i));
		end

		// Host write and readback of every register
		for (int i = 0; i < `ALU_NREGS; i++) begin
			rnd = $random(seed);
			rand_vals[i] = rnd[`ALU_WIDTH-1:0];
			apb_write(reg_byte_addr(i), {16'h0, rand_vals[i]}, err);
			check_bit(1'b0, err, "pslverr");
		end
		for (int i = 0; i < `ALU_NREGS; i++) begin
			apb_read(reg_byte_addr(i), rdata, err);
			check_word(rand_vals[i], rdata[`ALU_WIDTH-1:0], $sformatf("R%0d", i));
			check_bit(1'b0, err, "pslverr");
		end

		v = 0;
		while (v < MAX_VECS && vec_mem[v*VEC_WORDS] != 16'h0) begin
			run_vector(v * VEC_WORDS);
			v++;
		end
		if (v == 0) begin
			$display("No test vectors were read from the data file");
			other_errors++;
		end

		// Unmapped address aliases R4 in its low bits
		apb_write(ADDR_BAD, 32'h0000beef, err);
		check_bit(1'b1, err, "pslverr on unmapped write");
		apb_read(ADDR_BAD, rdata, err);
		check_bit(1'b1, err, "pslverr on unmapped read");
		apb_read(reg_byte_addr(4), rdata, err);
		check_word(rand_vals[4], rdata[`ALU_WIDTH-1:0], "R4");

		// STATUS is read only
		apb_write(`ALU_ADDR_STATUS, 32'h0000001f, err);
		check_bit(1'b1, err, "pslverr on STATUS write");
		apb_read(`ALU_ADDR_STATUS, rdata, err);
		check_word({11'h0, last_flags, 1'b0}, rdata[`ALU_WIDTH-1:0], "STATUS");

		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* test/alu_input.txt */
// kind op a b reps rd_init exp_rd exp_flags, flags are {sign carry zero parity}
// kind 1 single run, 2 repeated run, 3 flags only, 4 run with busy accesses, 0 ends
1 0 1234 8001 0 5a5a 8001 9
1 1 ffff 0001 0 5a5a 0000 6
1 2 0003 0005 0 5a5a fffe c
1 3 0100 0100 0 5a5a 0000 3
1 4 f0f0 0f0f 0 5a5a ffff 9
1 5 f0f0 0f0f 0 5a5a 0000 2
1 6 ff00 0ff0 0 5a5a f0f0 8
1 7 c001 0012 0 5a5a 0004 4
1 8 8000 0014 0 5a5a 0800 0
1 9 8000 0004 0 5a5a f800 8
1 a 1234 0034 0 5a5a 4123 1
1 b 00f0 0025 0 5a5a 0020 0
1 c 0000 001f 0 5a5a 8000 8
1 d ffff 0000 0 5a5a fffe 8
3 e 0005 0005 0 5a5a 5a5a 2
1 f 0080 0007 0 5a5a ff80 8
2 1 0001 0002 3 5a5a 0009 0
2 7 0001 0004 3 5a5a 0000 6
2 3 0003 0003 2 5a5a 0051 0
2 2 0010 0003 7 5a5a fff8 8
2 a 1234 0004 3 5a5a 1234 0
4 0 1111 2222 7 5a5a 2222 0
0 0 0000 0000 0 0000 0000 0

/* files.f */
+incdir+include
rtl/alu_pkg.sv
rtl/rf_if.sv
rtl/alu.sv
rtl/rep_counter.sv
rtl/reg_file.sv
rtl/exec_ctrl.sv
rtl/apb_regs.sv
rtl/alu_unit_top.sv
test/tb_clock.sv
test/tb_alu_unit.sv
